// File: logic/pong_pkg.sv
// pong engine types for commands, reports and ball direction, with fixed game constants
`default_nettype none

package pong_pkg;

  // ----------------------------------------
  // fixed game constants
  // ----------------------------------------
  localparam int coord_w             = 12;
  localparam int interval_w          = 16;
  localparam int ball_size           = 16;
  localparam int paddle_len          = 24;
  localparam int min_interval        = 4;
  localparam int bounces_per_halving = 5;
  localparam int max_halvings        = 9;

  // ----------------------------------------
  // command word
  // ----------------------------------------
  typedef enum logic {
    cmd_move = 1'b0,
    cmd_ctrl = 1'b1
  } cmd_kind_t;

  typedef struct packed {
    logic               player;  // 0 left, 1 right
    logic [coord_w-1:0] row;
  } move_payload_t;

  typedef struct packed {
    logic       serve;
    logic       clear_scores;
    logic       difficulty;  // high selects the hard decrement
    logic [9:0] spare;
  } ctrl_payload_t;

  // same 13 bits, read as a move or as a control word
  typedef union packed {
    move_payload_t move;
    ctrl_payload_t ctrl;
  } cmd_payload_u;

  typedef struct packed {
    cmd_kind_t    kind;
    cmd_payload_u payload;
  } cmd_t;

  // ----------------------------------------
  // ball state and report
  // ----------------------------------------
  // bit 0 flips vertical motion, both bits flip horizontal motion
  typedef enum logic [1:0] {
    up_right   = 2'd0,
    down_right = 2'd1,
    down_left  = 2'd2,
    up_left    = 2'd3
  } dir_t;

  typedef enum logic [1:0] {
    step        = 2'd0,
    wall_bounce = 2'd1,
    paddle_hit  = 2'd2,
    miss        = 2'd3
  } ball_event_t;

  typedef struct packed {
    logic [coord_w-1:0] x;
    logic [coord_w-1:0] y;
    logic [1:0]         score_p1;
    logic [1:0]         score_p2;
    ball_event_t        evt;
    logic [7:0]         seq;
  } report_t;

  typedef struct packed {
    logic [coord_w-1:0] left;
    logic [coord_w-1:0] right;
  } paddle_pos_t;

endpackage

`default_nettype wire

// File: logic/paddle_input.sv
// command intake that keeps clamped paddle rows and issues serve, clear and difficulty requests
`timescale 1ns/1ps
`default_nettype none

module paddle_input
  import pong_pkg::*;
#(
  parameter int field_h = 768
) (
  input  logic        pclk,
  input  logic        rst,
  input  cmd_t        cmd,
  input  logic        cmd_valid,
  output logic        cmd_ready,
  input  logic        ball_moving,
  output paddle_pos_t paddles,
  output logic        serve_req,
  output logic        clear_req,
  output logic        hard_mode
);

  localparam logic [coord_w-1:0] row_max = coord_w'(field_h - paddle_len);

  logic               accept;
  logic               is_move;
  logic               is_serve;
  move_payload_t      move_word;
  ctrl_payload_t      ctrl_word;
  logic [coord_w-1:0] row_clamped;

  // both views of the payload, kind says which one is live
  assign move_word = cmd.payload.move;
  assign ctrl_word = cmd.payload.ctrl;
  assign is_move   = (cmd.kind == cmd_move);
  assign is_serve  = !is_move && ctrl_word.serve;

  // serve waits for the ball to come to rest, a pending request counts as moving
  assign cmd_ready = !(is_serve && (ball_moving || serve_req));
  assign accept    = cmd_valid && cmd_ready;

  // keep the whole paddle inside the field
  assign row_clamped = (move_word.row > row_max) ? row_max : move_word.row;

  // ----------------------------------------
  // paddle rows and request pulses
  // ----------------------------------------
  always_ff @(posedge pclk) begin
    if (rst) begin
      paddles   <= '0;
      serve_req <= 1'b0;
      clear_req <= 1'b0;
      hard_mode <= 1'b0;
    end else begin
      serve_req <= accept && is_serve;
      clear_req <= accept && !is_move && ctrl_word.clear_scores;
      if (accept && is_move) begin
        if (move_word.player)
          paddles.right <= row_clamped;
        else
          paddles.left <= row_clamped;
      end
      // difficulty is a level, every control word rewrites it
      if (accept && !is_move)
        hard_mode <= ctrl_word.difficulty;
    end
  end

endmodule

`default_nettype wire

// File: logic/ball_motion.sv
// ball FSM with step timer, wall and paddle bounces, speed-up and score keeping
`timescale 1ns/1ps
`default_nettype none

module ball_motion
  import pong_pkg::*;
#(
  parameter int field_w    = 1024,
  parameter int field_h    = 768,
  parameter int step_start = 2000,
  parameter int dec_easy   = 8,
  parameter int dec_hard   = 64
) (
  input  logic        pclk,
  input  logic        rst,
  input  paddle_pos_t paddles,
  input  logic        serve_req,
  input  logic        clear_req,
  input  logic        hard_mode,
  output logic        ball_moving,
  output report_t     rpt,
  output logic        rpt_valid,
  input  logic        rpt_ready
);

  localparam logic [coord_w-1:0]    x_home    = coord_w'(field_w / 2 - 1);
  localparam logic [coord_w-1:0]    x_right   = coord_w'(field_w - 1 - ball_size);
  localparam logic [coord_w-1:0]    y_bottom  = coord_w'(field_h - 1 - ball_size);
  localparam logic [coord_w-1:0]    col_left  = coord_w'(field_w / 16);
  localparam logic [coord_w-1:0]    col_right = coord_w'(field_w - field_w / 16 - ball_size);
  localparam logic [interval_w-1:0] ivl_start = interval_w'(step_start);
  localparam logic [interval_w-1:0] ivl_min   = interval_w'(min_interval);
  localparam logic [interval_w-1:0] dec_e     = interval_w'(dec_easy);
  localparam logic [interval_w-1:0] dec_h     = interval_w'(dec_hard);

  typedef enum logic {
    st_idle,
    st_moving
  } state_t;

  state_t                state;
  logic [coord_w-1:0]    x;
  logic [coord_w-1:0]    y;
  dir_t                  dir;
  logic [interval_w-1:0] timer;
  logic [interval_w-1:0] interval;
  logic [interval_w-1:0] decr;
  logic [2:0]            bounce_cnt;
  logic [3:0]            halve_cnt;
  logic [1:0]            score_p1;
  logic [1:0]            score_p2;

  logic                  fire;
  logic                  going_left;
  logic                  hit_left;
  logic                  hit_right;
  logic [coord_w-1:0]    nx;
  logic [coord_w-1:0]    ny;
  ball_event_t           evt;
  dir_t                  dir_n;
  logic [interval_w-1:0] interval_n;
  logic [interval_w-1:0] decr_n;
  logic [2:0]            bounce_n;
  logic [3:0]            halve_n;
  logic [1:0]            p1_base;
  logic [1:0]            p2_base;
  logic [1:0]            p1_step;
  logic [1:0]            p2_step;

  assign ball_moving = (state == st_moving);
  assign rpt_valid   = ball_moving && (timer == interval - 1'b1);
  assign fire        = rpt_valid && rpt_ready;
  assign going_left  = (dir == down_left) || (dir == up_left);

  // one diagonal step, the top edge holds at row 0
  always_comb begin
    nx = going_left ? x - 1'b1 : x + 1'b1;
    if (dir == up_right || dir == up_left)
      ny = (y == '0) ? y : y - 1'b1;
    else
      ny = y + 1'b1;
  end

  // ball overlaps a paddle face, paddle row is its top
  assign hit_left  = going_left && (nx == col_left) &&
                     (ny + coord_w'(ball_size) >= paddles.left) &&
                     (ny <= paddles.left + coord_w'(paddle_len));
  assign hit_right = !going_left && (nx == col_right) &&
                     (ny + coord_w'(ball_size) >= paddles.right) &&
                     (ny <= paddles.right + coord_w'(paddle_len));

  // ----------------------------------------
  // step rules, first match wins
  // ----------------------------------------
  always_comb begin
    p1_base    = clear_req ? 2'd0 : score_p1;
    p2_base    = clear_req ? 2'd0 : score_p2;
    p1_step    = p1_base;
    p2_step    = p2_base;
    evt        = step;
    dir_n      = dir;
    interval_n = interval;
    decr_n     = decr;
    bounce_n   = bounce_cnt;
    halve_n    = halve_cnt;
    if (ny <= coord_w'(1) || ny >= y_bottom) begin
      evt   = wall_bounce;
      dir_n = dir_t'(dir ^ 2'b01);
      if (interval <= decr + ivl_min)
        interval_n = ivl_min;
      else
        interval_n = interval - decr;
      // every fifth bounce halves the decrement, limited number of times
      if (bounce_cnt == 3'(bounces_per_halving - 1)) begin
        bounce_n = '0;
        if (halve_cnt < 4'(max_halvings)) begin
          decr_n  = decr >> 1;
          halve_n = halve_cnt + 1'b1;
        end
      end else begin
        bounce_n = bounce_cnt + 1'b1;
      end
    end else if (nx <= coord_w'(1)) begin
      evt     = miss;
      p2_step = (p2_base == 2'd3) ? 2'd3 : p2_base + 2'd1;
    end else if (nx >= x_right) begin
      evt     = miss;
      p1_step = (p1_base == 2'd3) ? 2'd3 : p1_base + 2'd1;
    end else if (hit_left || hit_right) begin
      evt   = paddle_hit;
      dir_n = dir_t'(dir ^ 2'b11);
    end
  end

  // seq is stamped downstream
  assign rpt = '{x: nx, y: ny, score_p1: p1_step, score_p2: p2_step, evt: evt, seq: 8'd0};

  // ----------------------------------------
  // ball state registers
  // ----------------------------------------
  always_ff @(posedge pclk) begin
    if (rst) begin
      state      <= st_idle;
      x          <= x_home;
      y          <= '0;
      dir        <= up_left;
      timer      <= '0;
      interval   <= ivl_start;
      decr       <= dec_e;
      bounce_cnt <= '0;
      halve_cnt  <= '0;
      score_p1   <= '0;
      score_p2   <= '0;
    end else begin
      score_p1 <= fire ? p1_step : p1_base;
      score_p2 <= fire ? p2_step : p2_base;
      case (state)
        st_idle: begin
          if (serve_req) begin
            state      <= st_moving;
            x          <= x_home;
            y          <= paddles.left;
            dir        <= up_left;
            timer      <= '0;
            interval   <= ivl_start;
            decr       <= hard_mode ? dec_h : dec_e;
            bounce_cnt <= '0;
            halve_cnt  <= '0;
          end
        end
        st_moving: begin
          if (fire) begin
            x          <= nx;
            y          <= ny;
            dir        <= dir_n;
            interval   <= interval_n;
            decr       <= decr_n;
            bounce_cnt <= bounce_n;
            halve_cnt  <= halve_n;
            timer      <= '0;
            if (evt == miss)
              state <= st_idle;
          end else if (!rpt_valid) begin
            // timer holds at expiry until the report is taken
            timer <= timer + 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/report_out.sv
// one-entry report holder that stamps a step sequence number and drives valid/ready
`timescale 1ns/1ps
`default_nettype none

module report_out
  import pong_pkg::*;
#(
  parameter int field_w = 1024,
  parameter int field_h = 768
) (
  input  logic    pclk,
  input  logic    rst,
  input  report_t rpt,
  input  logic    rpt_valid,
  output logic    rpt_ready,
  output report_t out,
  output logic    out_valid,
  input  logic    out_ready
);

  logic [7:0] seq_cnt;
  logic       load;
  report_t    stamped;

  // free again in the same cycle the held entry leaves
  assign rpt_ready = !out_valid || out_ready;
  assign load      = rpt_valid && rpt_ready;

  // own sequence number on every report
  always_comb begin
    stamped     = rpt;
    stamped.seq = seq_cnt;
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      out_valid <= 1'b0;
      seq_cnt   <= '0;
    end else if (load) begin
      out_valid <= 1'b1;
      seq_cnt   <= seq_cnt + 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // held entry, only replaced on a load
  always_ff @(posedge pclk) begin
    if (load)
      out <= stamped;
  end

endmodule

`default_nettype wire

// File: logic/pong_core.sv
// pong ball and score engine top level joining command intake, ball motion and report output
`timescale 1ns/1ps
`default_nettype none

module pong_core
  import pong_pkg::*;
#(
  parameter int field_w    = 1024,
  parameter int field_h    = 768,
  parameter int step_start = 2000,
  parameter int dec_easy   = 8,
  parameter int dec_hard   = 64
) (
  input  logic    pclk,
  input  logic    rst,
  input  cmd_t    cmd,
  input  logic    cmd_valid,
  output logic    cmd_ready,
  output report_t out,
  output logic    out_valid,
  input  logic    out_ready
);

  paddle_pos_t paddles;
  logic        serve_req;
  logic        clear_req;
  logic        hard_mode;
  logic        ball_moving;
  report_t     rpt;
  logic        rpt_valid;
  logic        rpt_ready;

  // ----------------------------------------
  // input side
  // ----------------------------------------
  paddle_input #(
    .field_h (field_h)
  ) u_input (
    .pclk        (pclk),
    .rst         (rst),
    .cmd         (cmd),
    .cmd_valid   (cmd_valid),
    .cmd_ready   (cmd_ready),
    .ball_moving (ball_moving),
    .paddles     (paddles),
    .serve_req   (serve_req),
    .clear_req   (clear_req),
    .hard_mode   (hard_mode)
  );

  // ----------------------------------------
  // ball motion
  // ----------------------------------------
  ball_motion #(
    .field_w    (field_w),
    .field_h    (field_h),
    .step_start (step_start),
    .dec_easy   (dec_easy),
    .dec_hard   (dec_hard)
  ) u_motion (
    .pclk        (pclk),
    .rst         (rst),
    .paddles     (paddles),
    .serve_req   (serve_req),
    .clear_req   (clear_req),
    .hard_mode   (hard_mode),
    .ball_moving (ball_moving),
    .rpt         (rpt),
    .rpt_valid   (rpt_valid),
    .rpt_ready   (rpt_ready)
  );

  // ----------------------------------------
  // output side
  // ----------------------------------------
  report_out #(
    .field_w (field_w),
    .field_h (field_h)
  ) u_report (
    .pclk      (pclk),
    .rst       (rst),
    .rpt       (rpt),
    .rpt_valid (rpt_valid),
    .rpt_ready (rpt_ready),
    .out       (out),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

`default_nettype wire

// File: sim/pong_core_assert.sv
// report holder checks on output handshake stability and ball position bounds
`timescale 1ns/1ps
`default_nettype none

module pong_core_assert
  import pong_pkg::*;
#(
  parameter int field_w = 1024
) (
  input logic    pclk,
  input logic    rst,
  input report_t out,
  input logic    out_valid,
  input logic    out_ready
);

  // held entry may not change until taken
  hold_stable: assert property (@(posedge pclk) disable iff (rst)
    (out_valid && !out_ready) |=> (out_valid && $stable(out)))
    else $error("held report changed before it was accepted");

  x_in_field: assert property (@(posedge pclk) disable iff (rst)
    out_valid |-> (out.x < field_w))
    else $error("reported ball x lies outside the field");

endmodule

bind report_out pong_core_assert #(
  .field_w (field_w)
) u_assert (
  .pclk      (pclk),
  .rst       (rst),
  .out       (out),
  .out_valid (out_valid),
  .out_ready (out_ready)
);

`default_nettype wire

// File: sim/pong_core_tb.sv
// pong engine testbench with a ball step model, report checks and a closing summary
`timescale 1ns/1ps
`default_nettype none

module pong_core_tb
  import pong_pkg::*;
;
  localparam int field_w    = 128;
  localparam int field_h    = 96;
  localparam int step_start = 40;
  localparam int dec_easy   = 2;
  localparam int dec_hard   = 8;
  localparam int timeout    = 200000;

  typedef struct packed {
    logic [11:0] x;
    logic [11:0] y;
    dir_t        dir;
    logic [15:0] ivl;
    logic [15:0] decr;
    logic [2:0]  bcnt;
    logic [3:0]  hcnt;
    logic [1:0]  p1;
    logic [1:0]  p2;
  } model_t;

  logic        pclk;
  logic        rst;
  cmd_t        cmd;
  logic        cmd_valid;
  logic        cmd_ready;
  report_t     out;
  logic        out_valid;
  logic        out_ready;

  integer      seed;
  int          errors;
  int          checks;
  int          nrep;
  int          nhits;
  int          cyc;
  int          last_cyc;
  int          exp_gap;
  logic        stall_now;
  logic        stall_prev;
  logic        rand_ready;
  logic        moving_m;
  model_t      m;
  paddle_pos_t pd_m;
  logic [7:0]  seq_m;
  report_t     last_rpt;

  pong_core #(
    .field_w    (field_w),
    .field_h    (field_h),
    .step_start (step_start),
    .dec_easy   (dec_easy),
    .dec_hard   (dec_hard)
  ) u_dut (
    .pclk      (pclk),
    .rst       (rst),
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .out       (out),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial begin
    pclk = 1'b0;
    forever #10 pclk = ~pclk;
  end

  task automatic check(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic finish_run;
    $display("errors %0d checks %0d reports %0d", errors, checks, nrep);
    if (errors == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  endtask

  // ----------------------------------------
  // reference step model
  // ----------------------------------------
  function automatic model_t apply_step(input model_t s, input paddle_pos_t pd,
                                        output ball_event_t ev);
    model_t n;
    int     nx;
    int     ny;
    int     iv;
    logic   left;
    n    = s;
    left = (s.dir == down_left) || (s.dir == up_left);
    nx   = left ? int'(s.x) - 1 : int'(s.x) + 1;
    if (s.dir == up_right || s.dir == up_left)
      ny = (s.y == 0) ? 0 : int'(s.y) - 1;
    else
      ny = int'(s.y) + 1;
    n.x = 12'(nx);
    n.y = 12'(ny);
    ev  = step;
    if (ny <= 1 || ny >= field_h - 1 - ball_size) begin
      ev = wall_bounce;
      case (s.dir)
        up_right:   n.dir = down_right;
        down_right: n.dir = up_right;
        down_left:  n.dir = up_left;
        default:    n.dir = down_left;
      endcase
      iv    = int'(s.ivl) - int'(s.decr);
      n.ivl = 16'((iv < 4) ? 4 : iv);
      if (s.bcnt == 4) begin
        n.bcnt = 0;
        if (s.hcnt < 9) begin
          n.decr = s.decr / 2;
          n.hcnt = s.hcnt + 1;
        end
      end else begin
        n.bcnt = s.bcnt + 1;
      end
    end else if (nx <= 1) begin
      ev   = miss;
      n.p2 = (s.p2 == 3) ? 2'd3 : s.p2 + 2'd1;
    end else if (nx >= field_w - 1 - ball_size) begin
      ev   = miss;
      n.p1 = (s.p1 == 3) ? 2'd3 : s.p1 + 2'd1;
    end else if ((left && nx == field_w / 16 && ny >= int'(pd.left) - ball_size &&
                  ny <= int'(pd.left) + paddle_len) ||
                 (!left && nx == field_w - field_w / 16 - ball_size &&
                  ny >= int'(pd.right) - ball_size && ny <= int'(pd.right) + paddle_len)) begin
      ev = paddle_hit;
      case (s.dir)
        up_right:   n.dir = up_left;
        up_left:    n.dir = up_right;
        down_right: n.dir = down_left;
        default:    n.dir = down_right;
      endcase
    end
    return n;
  endfunction

  // ----------------------------------------
  // report compare
  // ----------------------------------------
  always @(posedge pclk) begin : compare
    model_t      nm;
    ball_event_t ev;
    cyc = cyc + 1;
    if (!rst && out_valid && !out_ready)
      stall_now = 1'b1;
    if (!rst && out_valid && out_ready) begin
      if (!moving_m) begin
        errors++;
        $display("a report arrived at %0t while the ball should be idle", $time);
      end
      nm = apply_step(m, pd_m, ev);
      check("out.x", out.x, nm.x);
      check("out.y", out.y, nm.y);
      check("out.evt", out.evt, ev);
      check("out.score_p1", out.score_p1, nm.p1);
      check("out.score_p2", out.score_p2, nm.p2);
      check("out.seq", out.seq, seq_m);
      // gaps only count when neither this nor the previous report was held
      if (!stall_now && !stall_prev)
        check("report gap", cyc - last_cyc, exp_gap);
      stall_prev = stall_now;
      stall_now  = 1'b0;
      last_cyc   = cyc;
      exp_gap    = nm.ivl;
      m          = nm;
      seq_m      = seq_m + 8'd1;
      last_rpt   = out;
      nrep++;
      if (ev == paddle_hit)
        nhits++;
      if (ev == miss)
        moving_m = 1'b0;
    end
  end

  // ready pattern, random in the back-pressure phase
  always @(posedge pclk) begin
    #2;
    out_ready <= rand_ready ? (($random(seed) & 1) != 0) : 1'b1;
  end

  // ----------------------------------------
  // stimulus tasks
  // ----------------------------------------
  task automatic send(input cmd_t c, output int waits);
    logic done;
    done  = 1'b0;
    waits = 0;
    @(posedge pclk);
    #2;
    cmd       = c;
    cmd_valid = 1'b1;
    while (!done) begin
      @(posedge pclk);
      if (cmd_ready) begin
        done = 1'b1;
      end else begin
        waits++;
        if (waits > timeout) begin
          errors++;
          $display("command handshake timed out at %0t", $time);
          finish_run();
        end
      end
    end
    #1;
    // model sees the command once the compare at this edge is done
    if (c.kind == cmd_move) begin
      if (c.payload.move.player)
        pd_m.right = (c.payload.move.row > field_h - paddle_len) ? 12'(field_h - paddle_len)
                                                                 : c.payload.move.row;
      else
        pd_m.left = (c.payload.move.row > field_h - paddle_len) ? 12'(field_h - paddle_len)
                                                                : c.payload.move.row;
    end else begin
      if (c.payload.ctrl.clear_scores) begin
        m.p1 = 2'd0;
        m.p2 = 2'd0;
      end
      if (c.payload.ctrl.serve) begin
        if (moving_m) begin
          errors++;
          $display("serve accepted at %0t while the ball was still moving", $time);
        end
        m.x        = 12'(field_w / 2 - 1);
        m.y        = pd_m.left;
        m.dir      = up_left;
        m.ivl      = 16'(step_start);
        m.decr     = c.payload.ctrl.difficulty ? 16'(dec_hard) : 16'(dec_easy);
        m.bcnt     = 3'd0;
        m.hcnt     = 4'd0;
        moving_m   = 1'b1;
        last_cyc   = cyc;
        exp_gap    = step_start + 2;
        stall_now  = 1'b0;
        stall_prev = 1'b0;
      end
    end
    #1;
    cmd_valid = 1'b0;
  endtask

  task automatic move_paddle(input logic player, input int row);
    cmd_t c;
    int   waits;
    c                     = '0;
    c.kind                = cmd_move;
    c.payload.move.player = player;
    c.payload.move.row    = 12'(row);
    send(c, waits);
  endtask

  task automatic control(input logic serve, input logic clear, input logic hard,
                         output int waits);
    cmd_t c;
    c                           = '0;
    c.kind                      = cmd_ctrl;
    c.payload.ctrl.serve        = serve;
    c.payload.ctrl.clear_scores = clear;
    c.payload.ctrl.difficulty   = hard;
    send(c, waits);
  endtask

  task automatic wait_idle;
    int n;
    n = 0;
    while (moving_m) begin
      @(posedge pclk);
      n++;
      if (n > timeout) begin
        errors++;
        $display("ball never came to rest, timed out at %0t", $time);
        finish_run();
      end
    end
  endtask

  task automatic wait_reports(input int target);
    int n;
    n = 0;
    while (nrep < target) begin
      @(posedge pclk);
      #1;
      n++;
      if (n > timeout) begin
        errors++;
        $display("expected report did not arrive, timed out at %0t", $time);
        finish_run();
      end
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    int waits;
    int i;
    int n0;
    seed       = 32'h528a;
    errors     = 0;
    checks     = 0;
    nrep       = 0;
    nhits      = 0;
    cyc        = 0;
    last_cyc   = 0;
    exp_gap    = 0;
    stall_now  = 1'b0;
    stall_prev = 1'b0;
    rand_ready = 1'b0;
    moving_m   = 1'b0;
    m          = '0;
    pd_m       = '0;
    seq_m      = 8'd0;
    last_rpt   = '0;
    rst        = 1'b1;
    cmd        = '0;
    cmd_valid  = 1'b0;
    out_ready  = 1'b1;
    repeat (16) @(posedge pclk);
    #2;
    rst = 1'b0;

    // quiet after reset, a serve word without valid shows the idle ball
    cmd.kind               = cmd_ctrl;
    cmd.payload.ctrl.serve = 1'b1;
    for (i = 0; i < 60; i++) begin
      @(posedge pclk);
      check("out_valid", out_valid, 0);
      check("cmd_ready", cmd_ready, 1);
    end

    // hard rally with both paddles placed to return the ball once
    move_paddle(1'b0, 20);
    move_paddle(1'b1, 20);
    control(1'b1, 1'b0, 1'b1, waits);
    control(1'b1, 1'b0, 1'b1, waits);
    check("serve held off", waits > 0, 1);
    wait_idle();
    check("paddle hits seen", nhits > 0, 1);

    // back-pressure, clear, clamped paddle and repeated left misses
    rand_ready = 1'b1;
    control(1'b0, 1'b1, 1'b0, waits);
    move_paddle(1'b0, 500);
    for (i = 0; i < 4; i++) begin
      n0 = nrep;
      control(1'b1, 1'b0, 1'b0, waits);
      if (i == 0) begin
        wait_reports(n0 + 1);
        check("clamped serve y", last_rpt.y, field_h - paddle_len - 1);
        check("cleared score_p2", last_rpt.score_p2, 0);
      end
      wait_idle();
    end
    check("saturated score_p2", last_rpt.score_p2, 3);
    check("score_p1", last_rpt.score_p1, 0);
    repeat (50) @(posedge pclk);
    finish_run();
  end

endmodule

`default_nettype wire

// File: pong_core.f
logic/pong_pkg.sv
logic/paddle_input.sv
logic/ball_motion.sv
logic/report_out.sv
logic/pong_core.sv
sim/pong_core_assert.sv
sim/pong_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the pong engine testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  -f pong_core.f --top-module pong_core_tb -o sim_pong
./obj_dir/sim_pong > sim.log 2>&1 || true
cat sim.log
if grep -q "^Done: no errors$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
